// ==== lsu.f ====
verilog/lsu_pkg.sv
verilog/lsu_issue.sv
verilog/lsu_pend_queue.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the lsu testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module lsu_tb -f lsu.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

   localparam int          PEND_DEPTH = 4;
   localparam int          N_OPS      = 300;
   localparam int          MAX_CYCLES = N_OPS * 8 + 100;
   localparam logic [31:0] SEED       = 32'h282e_dd23;

   typedef struct packed {
      int          due;
      logic [31:0] rdata;
      logic        sc_ok;
   } resp_t;

   logic             clk = 1'b0;
   logic             rst_n;
   logic             issue_valid;
   lsu_req_t         issue;
   logic             issue_ready;
   logic             mem_req_valid;
   mem_req_t         mem_req;
   logic             mem_addr_ok = 1'b0;
   logic             mem_data_ok = 1'b0;
   logic [GRLEN-1:0] mem_rdata = '0;
   logic             mem_sc_ok = 1'b0;
   logic             result_valid;
   lsu_result_t      result;

   logic [31:0] stim_rng = SEED;
   logic [31:0] mem_rng = ~SEED;
   logic        sc_pick = 1'b0;
   logic        quiet = 1'b1;
   int          resp_delay = 1;
   int          resp_free = 0;
   int          cycle = 0;
   int          errors = 0;
   int          n_issued = 0;
   int          n_results = 0;
   logic [31:0] model_mem [256];
   logic [31:0] ref_mem [256];
   resp_t       resp_q [$];
   lsu_result_t exp_q [$];

   // scoreboard state as seen between clock edges
   logic        exp_valid = 1'b0;
   lsu_result_t exp_head = '0;
   int          outstanding = 0;
   mem_req_t    chk_req;
   logic        chk_ale;

   lsu_top #(
      .PEND_DEPTH (PEND_DEPTH)
   ) UUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid   (issue_valid),
      .issue         (issue),
      .issue_ready   (issue_ready),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .mem_addr_ok   (mem_addr_ok),
      .mem_data_ok   (mem_data_ok),
      .mem_rdata     (mem_rdata),
      .mem_sc_ok     (mem_sc_ok),
      .result_valid  (result_valid),
      .result        (result)
   );

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic int op_size(input lsu_op_e op);
      case (op)
         LD_B, LD_BU, ST_B: return 1;
         LD_H, LD_HU, ST_H: return 2;
         default:           return 4;
      endcase
   endfunction

   function automatic logic misaligned(input lsu_op_e op, input logic [31:0] a);
      return (a & 32'(op_size(op) - 1)) != 0;
   endfunction

   function automatic mem_req_t expect_req(input lsu_req_t r);
      mem_req_t    m;
      logic [31:0] a;
      a       = r.base + r.offset;
      m.addr  = a;
      m.wr    = r.op inside {ST_B, ST_H, ST_W, SC_W};
      m.ll    = (r.op == LL_W);
      m.sc    = (r.op == SC_W);
      m.wstrb = 4'b1111;
      m.wdata = r.wdata;
      if (op_size(r.op) == 1) begin
         m.wstrb = 4'b0001 << a[1:0];
         m.wdata = {4{r.wdata[7:0]}};
      end else if (op_size(r.op) == 2) begin
         m.wstrb = 4'b0011 << a[1:0];
         m.wdata = {2{r.wdata[15:0]}};
      end
      return m;
   endfunction

   function automatic lsu_result_t expect_result(input lsu_req_t r, input logic [31:0] word,
                                                 input logic sc_ok);
      lsu_result_t res;
      logic [31:0] a;
      logic [31:0] sh;
      a        = r.base + r.offset;
      sh       = word >> {a[1:0], 3'b000};
      res.rd   = r.rd;
      res.wen  = r.wen;
      res.ale  = misaligned(r.op, a);
      res.data = '0;
      if (!res.ale) begin
         case (r.op)
            LD_B:       res.data = {{24{sh[7]}}, sh[7:0]};
            LD_BU:      res.data = {24'h0, sh[7:0]};
            LD_H:       res.data = {{16{sh[15]}}, sh[15:0]};
            LD_HU:      res.data = {16'h0, sh[15:0]};
            LD_W, LL_W: res.data = word;
            SC_W:       res.data = {31'h0, sc_ok};
            default:    res.data = '0;
         endcase
      end
      return res;
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                         input logic [3:0] strb);
      logic [31:0] w;
      w = old;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) begin
            w[8*i +: 8] = data[8*i +: 8];
         end
      end
      return w;
   endfunction

   task automatic log_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   assign chk_req = expect_req(issue);
   assign chk_ale = misaligned(issue.op, chk_req.addr);

   initial begin
      forever #5 clk = ~clk;
   end

   // memory model and scoreboard, both in request order
   always @(posedge clk) begin
      lsu_result_t r;
      resp_t       rsp;
      logic [7:0]  idx;
      cycle++;
      if (rst_n) begin
         if (mem_req_valid && mem_addr_ok) begin
            idx       = mem_req.addr[9:2];
            // delay counts from the later of the request and the previous response
            rsp.due   = ((cycle > resp_free) ? cycle : resp_free) + resp_delay - 1;
            resp_free = rsp.due + 1;
            rsp.rdata = model_mem[idx];
            rsp.sc_ok = mem_req.sc && sc_pick;
            if (mem_req.wr && (!mem_req.sc || sc_pick)) begin
               model_mem[idx] = merge(model_mem[idx], mem_req.wdata, mem_req.wstrb);
            end
            resp_q.push_back(rsp);
         end
         if (result_valid) begin
            if (exp_q.size() > 0) begin
               void'(exp_q.pop_front());
            end
            n_results++;
         end
         if (issue_valid && issue_ready) begin
            idx = chk_req.addr[9:2];
            r   = expect_result(issue, ref_mem[idx], sc_pick);
            if (!r.ale && chk_req.wr && (!chk_req.sc || sc_pick)) begin
               ref_mem[idx] = merge(ref_mem[idx], chk_req.wdata, chk_req.wstrb);
            end
            exp_q.push_back(r);
            n_issued++;
         end
      end
   end

   always @(negedge clk) begin
      mem_rng     = next_rand(mem_rng);
      mem_addr_ok = (mem_rng[1:0] != 2'b00);
      sc_pick     = mem_rng[8];
      resp_delay  = 1 + int'(mem_rng[20:16] % 3);
      mem_data_ok = 1'b0;
      mem_rdata   = '0;
      mem_sc_ok   = 1'b0;
      if (resp_q.size() > 0 && resp_q[0].due <= cycle) begin
         mem_data_ok = 1'b1;
         mem_rdata   = resp_q[0].rdata;
         mem_sc_ok   = resp_q[0].sc_ok;
         void'(resp_q.pop_front());
      end
      exp_valid   = exp_q.size() > 0;
      exp_head    = exp_valid ? exp_q[0] : '0;
      outstanding = exp_q.size();
   end

   a_quiet_reset: assert property (@(posedge clk) quiet |-> !mem_req_valid && !result_valid)
      else log_error("request or result valid during reset");
   a_req_ok: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && mem_addr_ok |-> issue_valid && issue_ready &&
         mem_req.addr == chk_req.addr && mem_req.wr == chk_req.wr &&
         mem_req.ll == chk_req.ll && mem_req.sc == chk_req.sc)
      else log_error($sformatf("bad request at addr %h", mem_req.addr));
   a_store_fmt: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && mem_addr_ok && chk_req.wr |->
         mem_req.wstrb == chk_req.wstrb && mem_req.wdata == chk_req.wdata)
      else log_error($sformatf("store strobe %b data %h, expected %b %h",
         mem_req.wstrb, mem_req.wdata, chk_req.wstrb, chk_req.wdata));
   a_no_ale_req: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid && chk_ale |-> !mem_req_valid)
      else log_error("misaligned operation sent to memory");
   a_result: assert property (@(posedge clk) disable iff (!rst_n)
      result_valid |-> exp_valid && result == exp_head)
      else log_error($sformatf("result data %h rd %0d wen %b ale %b, expected %h %0d %b %b",
         result.data, result.rd, result.wen, result.ale,
         exp_head.data, exp_head.rd, exp_head.wen, exp_head.ale));
   a_in_flight: assert property (@(posedge clk) outstanding <= PEND_DEPTH)
      else log_error($sformatf("%0d operations outstanding", outstanding));

   initial begin
      wait (cycle >= MAX_CYCLES);
      $display("timeout: no finish after %0d cycles, %0d results pending", MAX_CYCLES,
               exp_q.size());
      $display("Test failed");
      $finish;
   end

   initial begin
      lsu_req_t    req;
      logic [31:0] a;
      rst_n       = 1'b0;
      issue_valid = 1'b0;
      issue       = '0;
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = next_rand(32'(i) ^ 32'ha5a5_0000);
         ref_mem[i]   = model_mem[i];
      end
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      quiet = 1'b0;
      for (int k = 0; k < N_OPS; k++) begin
         stim_rng = next_rand(stim_rng);
         if (stim_rng[3:2] == 2'b00) begin
            issue_valid = 1'b0;
            @(negedge clk);
         end
         req.op   = lsu_op_e'(4'(stim_rng[31:8] % 10));
         stim_rng = next_rand(stim_rng);
         a        = stim_rng;
         stim_rng = next_rand(stim_rng);
         // roughly one in eight halfword or word ops lands misaligned
         if (stim_rng[2:0] == 3'b000) begin
            a[0] = 1'b1;
         end else begin
            a = a & ~32'(op_size(req.op) - 1);
         end
         req.base    = stim_rng;
         req.offset  = a - stim_rng;
         stim_rng    = next_rand(stim_rng);
         req.wdata   = stim_rng;
         stim_rng    = next_rand(stim_rng);
         req.rd      = stim_rng[4:0];
         req.wen     = stim_rng[5];
         issue       = req;
         issue_valid = 1'b1;
         @(negedge clk);
         while (n_issued == k) @(negedge clk);
      end
      issue_valid = 1'b0;
      while (n_results < n_issued) @(negedge clk);
      repeat (4) @(negedge clk);
      assert (n_results == n_issued)
         else log_error($sformatf("%0d issued, %0d results", n_issued, n_results));
      $display("lsu_tb: %0d operations, %0d results, %0d errors", n_issued, n_results, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== verilog/lsu_issue.sv ====
`timescale 1ns/10ps

module lsu_issue import lsu_pkg::*; (
   input  logic     issue_valid,
   input  lsu_req_t issue,
   output logic     issue_ready,

   input  logic     mem_addr_ok,
   output logic     mem_req_valid,
   output mem_req_t mem_req,

   input  logic     pend_full,
   output logic     pend_push,
   output pend_t    pend_entry
);

   logic [GRLEN-1:0] addr;
   logic             is_half;
   logic             is_word;
   logic             is_store;
   logic             is_ll;
   logic             is_sc;
   logic             ale;
   logic [3:0]       strb;
   logic [GRLEN-1:0] wdata_fmt;

   assign addr = issue.base + issue.offset;

   // access size and kind
   always_comb begin
      is_half  = 1'b0;
      is_word  = 1'b0;
      is_store = 1'b0;
      is_ll    = 1'b0;
      is_sc    = 1'b0;
      case (issue.op)
         LD_H, LD_HU: is_half = 1'b1;
         LD_W:        is_word = 1'b1;
         ST_B:        is_store = 1'b1;
         ST_H: begin
            is_half  = 1'b1;
            is_store = 1'b1;
         end
         ST_W: begin
            is_word  = 1'b1;
            is_store = 1'b1;
         end
         LL_W: begin
            is_word = 1'b1;
            is_ll   = 1'b1;
         end
         SC_W: begin
            is_word  = 1'b1;
            is_store = 1'b1;
            is_sc    = 1'b1;
         end
         default: ;
      endcase
   end

   // natural alignment
   assign ale = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

   always_comb begin
      if (is_word) begin
         strb      = 4'b1111;
         wdata_fmt = issue.wdata;
      end else if (is_half) begin
         strb      = 4'b0011 << addr[1:0];
         wdata_fmt = {2{issue.wdata[15:0]}};
      end else begin
         strb      = 4'b0001 << addr[1:0];
         wdata_fmt = {4{issue.wdata[7:0]}};
      end
   end

   // a misaligned op never reaches memory, so it does not wait for addr_ok
   assign mem_req_valid = issue_valid && !ale && !pend_full;
   assign issue_ready   = !pend_full && (ale || mem_addr_ok);
   assign pend_push     = issue_valid && issue_ready;

   assign mem_req.addr  = addr;
   assign mem_req.wr    = is_store;
   assign mem_req.wstrb = is_store ? strb : 4'b0000;
   assign mem_req.wdata = wdata_fmt;
   assign mem_req.ll    = is_ll;
   assign mem_req.sc    = is_sc;

   assign pend_entry.op      = issue.op;
   assign pend_entry.addr_lo = addr[1:0];
   assign pend_entry.rd      = issue.rd;
   assign pend_entry.wen     = issue.wen;
   assign pend_entry.ale     = ale;

endmodule

// ==== verilog/lsu_load_align.sv ====
`timescale 1ns/10ps

module lsu_load_align import lsu_pkg::*; (
   input  pend_t            head,
   input  logic             head_valid,
   input  logic             mem_data_ok,
   input  logic [GRLEN-1:0] mem_rdata,
   input  logic             mem_sc_ok,
   output logic             pop,
   output logic             result_valid,
   output lsu_result_t      result
);

   logic             done;
   logic [7:0]       sel_byte;
   logic [15:0]      sel_half;
   logic [GRLEN-1:0] load_data;

   // errored ops have no memory response to wait for
   assign done = head_valid && (head.ale || mem_data_ok);

   assign pop          = done;
   assign result_valid = done;

   assign sel_byte = mem_rdata[{head.addr_lo, 3'b000} +: 8];
   assign sel_half = mem_rdata[{head.addr_lo[1], 4'b0000} +: 16];

   always_comb begin
      case (head.op)
         LD_B:       load_data = {{(GRLEN-8){sel_byte[7]}}, sel_byte};
         LD_BU:      load_data = {{(GRLEN-8){1'b0}}, sel_byte};
         LD_H:       load_data = {{(GRLEN-16){sel_half[15]}}, sel_half};
         LD_HU:      load_data = {{(GRLEN-16){1'b0}}, sel_half};
         LD_W, LL_W: load_data = mem_rdata;
         SC_W:       load_data = {{(GRLEN-1){1'b0}}, mem_sc_ok};
         // plain stores write nothing back
         default:    load_data = '0;
      endcase
   end

   assign result.data = head.ale ? '0 : load_data;
   assign result.rd   = head.rd;
   assign result.wen  = head.wen;
   assign result.ale  = head.ale;

endmodule

// ==== verilog/lsu_pend_queue.sv ====
`timescale 1ns/10ps

module lsu_pend_queue import lsu_pkg::*; #(
   parameter int PEND_DEPTH = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  push,
   input  pend_t entry,
   input  logic  pop,
   output pend_t head,
   output logic  head_valid,
   output logic  full
);

   localparam int PTR_W = $clog2(PEND_DEPTH);
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(PEND_DEPTH);

   pend_t            slots [PEND_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             tail_ale;

   always_ff @(posedge clk) begin
      if (push) begin
         slots[wr_ptr] <= entry;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         tail_ale <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr   <= wr_ptr + 1'b1;
            tail_ale <= entry.ale;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   assign head       = slots[rd_ptr];
   assign head_valid = (count != '0);

   // a misaligned entry completes without mem_data_ok, so nothing is
   // accepted behind it until it is the head and pops at once.
   // otherwise its completion could land on a later op's data_ok pulse
   assign full = (count == FULL_CNT) || (tail_ale && (count > (PTR_W+1)'(1)));

endmodule

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

   localparam int GRLEN  = 32;
   localparam int REG_AW = 5;

   // memory operation codes from the execute stage
   typedef enum logic [3:0] {
      LD_B  = 4'd0,
      LD_BU = 4'd1,
      LD_H  = 4'd2,
      LD_HU = 4'd3,
      LD_W  = 4'd4,
      ST_B  = 4'd5,
      ST_H  = 4'd6,
      ST_W  = 4'd7,
      LL_W  = 4'd8,
      SC_W  = 4'd9
   } lsu_op_e;

   typedef struct packed {
      lsu_op_e           op;
      logic [GRLEN-1:0]  base;
      logic [GRLEN-1:0]  offset;
      logic [GRLEN-1:0]  wdata;
      logic [REG_AW-1:0] rd;
      logic              wen;
   } lsu_req_t;

   typedef struct packed {
      logic [GRLEN-1:0]  addr;
      logic              wr;
      logic [3:0]        wstrb;
      logic [GRLEN-1:0]  wdata;
      logic              ll;
      logic              sc;
   } mem_req_t;

   // what the completion side needs to remember per operation
   typedef struct packed {
      lsu_op_e           op;
      logic [1:0]        addr_lo;
      logic [REG_AW-1:0] rd;
      logic              wen;
      logic              ale;
   } pend_t;

   typedef struct packed {
      logic [GRLEN-1:0]  data;
      logic [REG_AW-1:0] rd;
      logic              wen;
      logic              ale;
   } lsu_result_t;

endpackage

// ==== verilog/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; #(
   parameter int PEND_DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst_n,

   input  logic             issue_valid,
   input  lsu_req_t         issue,
   output logic             issue_ready,

   output logic             mem_req_valid,
   output mem_req_t         mem_req,
   input  logic             mem_addr_ok,
   input  logic             mem_data_ok,
   input  logic [GRLEN-1:0] mem_rdata,
   input  logic             mem_sc_ok,

   output logic             result_valid,
   output lsu_result_t      result
);

   logic  pend_full;
   logic  pend_push;
   pend_t pend_entry;
   pend_t pend_head;
   logic  pend_head_valid;
   logic  pend_pop;

   lsu_issue u_issue (
      .issue_valid   (issue_valid),
      .issue         (issue),
      .issue_ready   (issue_ready),
      .mem_addr_ok   (mem_addr_ok),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .pend_full     (pend_full),
      .pend_push     (pend_push),
      .pend_entry    (pend_entry)
   );

   lsu_pend_queue #(
      .PEND_DEPTH (PEND_DEPTH)
   ) u_pend_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (pend_push),
      .entry      (pend_entry),
      .pop        (pend_pop),
      .head       (pend_head),
      .head_valid (pend_head_valid),
      .full       (pend_full)
   );

   lsu_load_align u_load_align (
      .head         (pend_head),
      .head_valid   (pend_head_valid),
      .mem_data_ok  (mem_data_ok),
      .mem_rdata    (mem_rdata),
      .mem_sc_ok    (mem_sc_ok),
      .pop          (pend_pop),
      .result_valid (result_valid),
      .result       (result)
   );

endmodule
